//--- hw/ft245_macros.svh
// depths are log2 values and frame lengths are byte counts that must match the framing rules
`ifndef FT245_MACROS_SVH
`define FT245_MACROS_SVH

// the rx FIFO needs some depth because the host may stall for long stretches
`define FT_RX_DEPTH_LOG2 4

// the tx side only needs to smooth out the host writes
`define FT_TX_DEPTH_LOG2 3

// inbound header is command, 3 count bytes and 4 address bytes
`define FT_HDR_IN_BYTES 8

// outbound header is 4 status bytes, 4 address bytes and 3 count bytes
`define FT_HDR_OUT_BYTES 11

`endif

//--- hw/ft245_pin_pkg.sv
// chip pin level types only, the bus is 8 bits wide and has a single clock
`default_nettype none

package ft245_pin_pkg;

	// one byte on the chip data bus
	typedef logic [7:0] ft_byte_t;

	// the sequencer either waits, turns the bus around, reads or writes
	typedef enum logic [1:0] {
		IDLE,
		READ_OE,
		READ,
		WRITE
	} pin_state_t;

endpackage

`default_nettype wire

//--- hw/ft245_frame_pkg.sv
// frame level types, all multi byte fields are big endian and counts travel in 24 bits on the wire
`default_nettype none

package ft245_frame_pkg;

	// data, address and status words
	typedef logic [31:0] word_t;

	// word count, only the low 24 bits are carried in a frame
	typedef logic [27:0] count_t;

	// first byte of an inbound frame
	typedef logic [7:0] command_t;

	// the deframer is either in the 8 byte header or in the data words
	typedef enum logic {
		RX_HEADER,
		RX_DATA
	} rx_state_t;

	// the framer waits for a header, sends it, then sends the words
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_HEADER,
		TX_DATA
	} tx_state_t;

endpackage

`default_nettype wire

//--- hw/ft245_pin_seq.sv
// chip clock is clk, reads win over writes, and one byte of write data is held while the chip is full
`timescale 1ns/1ps
`default_nettype none

module ft245_pin_seq (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      ftdi_rde_n,
	input  wire                      ftdi_txe_n,
	input  wire ft245_pin_pkg::ft_byte_t ftdi_data_in,
	input  wire                      rx_hold,
	input  wire ft245_pin_pkg::ft_byte_t tx_byte,
	input  wire                      tx_byte_valid,
	output logic                     ftdi_rd_n,
	output logic                     ftdi_wr_n,
	output logic                     ftdi_oe_n,
	output ft245_pin_pkg::ft_byte_t  ftdi_data_drive,
	output ft245_pin_pkg::ft_byte_t  rx_byte,
	output logic                     rx_byte_strobe,
	output logic                     tx_byte_take
);

	ft245_pin_pkg::pin_state_t state;

	// write byte waiting for the chip, it survives a full chip or a read in between
	ft245_pin_pkg::ft_byte_t byte_q;
	logic byte_full;

	// edge flags seen by the chip itself
	logic rd_edge;
	logic sent;

	// the chip hands over a byte on every edge with both read strobes low
	assign rd_edge = !ftdi_rd_n && !ftdi_rde_n;

	// ftdi_wr_n is only low in WRITE, so a low txe_n there means the byte left
	assign sent = (state == ft245_pin_pkg::WRITE) && !ftdi_txe_n;

	// refill the holding byte when it is empty or is being sent this edge
	assign tx_byte_take = tx_byte_valid && (!byte_full || sent);

	// the top level gates this onto the pin with the strobes
	assign ftdi_data_drive = byte_q;

	// payload capture needs no reset
	always_ff @(posedge clk) begin
		if (rd_edge) begin
			rx_byte <= ftdi_data_in;
		end
		if (tx_byte_take) begin
			byte_q <= tx_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state          <= ft245_pin_pkg::IDLE;
			ftdi_rd_n      <= 1'b1;
			ftdi_wr_n      <= 1'b1;
			ftdi_oe_n      <= 1'b1;
			rx_byte_strobe <= 1'b0;
			byte_full      <= 1'b0;
		end else begin
			// strobe lines up with the captured byte one cycle after the edge
			rx_byte_strobe <= rd_edge;

			if (tx_byte_take) begin
				byte_full <= 1'b1;
			end else if (sent) begin
				byte_full <= 1'b0;
			end

			case (state)
				ft245_pin_pkg::IDLE: begin
					// a pending read is served first as long as the rx side has room
					if (!ftdi_rde_n && !rx_hold) begin
						ftdi_oe_n <= 1'b0;
						state     <= ft245_pin_pkg::READ_OE;
					end else if (ftdi_rde_n && !ftdi_txe_n && (byte_full || tx_byte_valid)) begin
						// a byte taken here is already in byte_q when wr_n falls
						ftdi_wr_n <= 1'b0;
						state     <= ft245_pin_pkg::WRITE;
					end
				end
				ft245_pin_pkg::READ_OE: begin
					// the chip needs one cycle with oe_n low before rd_n drops
					if (ftdi_rde_n || rx_hold) begin
						ftdi_oe_n <= 1'b1;
						state     <= ft245_pin_pkg::IDLE;
					end else begin
						ftdi_rd_n <= 1'b0;
						state     <= ft245_pin_pkg::READ;
					end
				end
				ft245_pin_pkg::READ: begin
					// an edge that ends the read still captures its byte above
					if (ftdi_rde_n || rx_hold) begin
						ftdi_rd_n <= 1'b1;
						ftdi_oe_n <= 1'b1;
						state     <= ft245_pin_pkg::IDLE;
					end
				end
				ft245_pin_pkg::WRITE: begin
					// stay only while the chip accepts and the next byte is loaded
					// a pending read also breaks off the burst
					if (!sent || !tx_byte_valid || !ftdi_rde_n) begin
						ftdi_wr_n <= 1'b1;
						state     <= ft245_pin_pkg::IDLE;
					end
				end
				default: begin
					state <= ft245_pin_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/frame_deframer.sv
// expects frames back to back with no resync, counts above 24 bits cannot be received
`timescale 1ns/1ps
`default_nettype none
`include "ft245_macros.svh"

module frame_deframer (
	input  wire                          clk,
	input  wire                          rst,
	input  wire ft245_pin_pkg::ft_byte_t rx_byte,
	input  wire                          rx_byte_strobe,
	output ft245_frame_pkg::command_t    in_command,
	output ft245_frame_pkg::count_t      in_data_count,
	output ft245_frame_pkg::word_t       in_address,
	output logic                         ih_ready,
	output logic                         push,
	output ft245_frame_pkg::word_t       push_word
);

	ft245_frame_pkg::rx_state_t state;

	// byte position inside the header
	logic [2:0] hdr_idx;

	// byte position inside the current data word
	logic [1:0] byte_idx;

	// words still expected in this frame
	ft245_frame_pkg::count_t words_left;

	// header fields and the data word are shifted in most significant byte first
	always_ff @(posedge clk) begin
		if (rx_byte_strobe) begin
			if (state == ft245_frame_pkg::RX_HEADER) begin
				case (hdr_idx)
					3'd0: in_command <= rx_byte;
					3'd1, 3'd2, 3'd3: in_data_count <= {4'h0, in_data_count[15:0], rx_byte};
					default: in_address <= {in_address[23:0], rx_byte};
				endcase
			end else begin
				// the word stays stable in the cycle that push is high
				push_word <= {push_word[23:0], rx_byte};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ft245_frame_pkg::RX_HEADER;
			hdr_idx    <= '0;
			byte_idx   <= '0;
			words_left <= '0;
			ih_ready   <= 1'b0;
			push       <= 1'b0;
		end else begin
			ih_ready <= 1'b0;
			push     <= 1'b0;

			if (rx_byte_strobe) begin
				case (state)
					ft245_frame_pkg::RX_HEADER: begin
						hdr_idx <= hdr_idx + 3'd1;
						if (hdr_idx == 3'(`FT_HDR_IN_BYTES - 1)) begin
							// the count was complete after the fourth byte
							hdr_idx    <= '0;
							byte_idx   <= '0;
							ih_ready   <= 1'b1;
							words_left <= in_data_count;
							// an empty frame goes straight on to the next header
							if (in_data_count != '0) begin
								state <= ft245_frame_pkg::RX_DATA;
							end
						end
					end
					ft245_frame_pkg::RX_DATA: begin
						byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'd3) begin
							push       <= 1'b1;
							words_left <= words_left - 1'b1;
							if (words_left == 28'd1) begin
								state <= ft245_frame_pkg::RX_HEADER;
							end
						end
					end
					default: begin
						state <= ft245_frame_pkg::RX_HEADER;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/word_fifo.sv
// push is ignored when full and the popped word arrives one cycle after pull
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
	parameter int DEPTH_LOG2 = 4
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         push,
	input  wire ft245_frame_pkg::word_t push_word,
	input  wire                         pull,
	output ft245_frame_pkg::word_t      pop_word,
	output logic                        pop_strobe,
	output logic                        room,
	output logic                        hold
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	ft245_frame_pkg::word_t mem [DEPTH];

	// pointers carry one extra bit so full and empty differ
	logic [DEPTH_LOG2:0] wr_ptr;
	logic [DEPTH_LOG2:0] rd_ptr;
	logic [DEPTH_LOG2:0] used;
	logic [DEPTH_LOG2:0] free;
	logic do_push;
	logic do_pop;

	assign used = wr_ptr - rd_ptr;
	assign free = (DEPTH_LOG2 + 1)'(DEPTH) - used;

	// hold leaves two slots for words still on their way in
	assign room = (free != '0);
	assign hold = (free <= 2);

	assign do_push = push && room;
	assign do_pop  = pull && (used != '0);

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= push_word;
		end
		if (do_pop) begin
			pop_word <= mem[rd_ptr[DEPTH_LOG2-1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			pop_strobe <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			pop_strobe <= do_pop;
		end
	end

endmodule

`default_nettype wire

//--- hw/frame_framer.sv
// only the low 24 bits of out_data_count are sent and counted, oh_en is ignored while busy
`timescale 1ns/1ps
`default_nettype none
`include "ft245_macros.svh"

module frame_framer (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         oh_en,
	input  wire ft245_frame_pkg::word_t out_status,
	input  wire ft245_frame_pkg::word_t out_address,
	input  wire ft245_frame_pkg::count_t out_data_count,
	input  wire ft245_frame_pkg::word_t pop_word,
	input  wire                         pop_strobe,
	input  wire                         tx_byte_take,
	output logic                        out_busy,
	output logic                        pull,
	output ft245_pin_pkg::ft_byte_t     tx_byte,
	output logic                        tx_byte_valid
);

	localparam int HDR_W = `FT_HDR_OUT_BYTES * 8;

	ft245_frame_pkg::tx_state_t state;

	// header bytes leave from the top of this register
	logic [HDR_W-1:0] hdr_sr;
	logic [3:0] hdr_idx;

	// the one data word in hand, shifted as its bytes go out
	ft245_frame_pkg::word_t word_sr;
	logic word_full;
	logic [1:0] byte_idx;

	ft245_frame_pkg::count_t words_left;

	// a pull is answered one cycle later, so pull is never high two cycles running
	logic pull_wait;

	assign out_busy = (state != ft245_frame_pkg::TX_IDLE);
	assign pull = (state == ft245_frame_pkg::TX_DATA) && !word_full && !pull_wait;

	// data bytes are offered only once a word has come out of the FIFO
	assign tx_byte_valid = (state == ft245_frame_pkg::TX_HEADER) ||
		((state == ft245_frame_pkg::TX_DATA) && word_full);
	assign tx_byte = (state == ft245_frame_pkg::TX_HEADER) ? hdr_sr[HDR_W-1 -: 8] : word_sr[31:24];

	always_ff @(posedge clk) begin
		if ((state == ft245_frame_pkg::TX_IDLE) && oh_en) begin
			hdr_sr <= {out_status, out_address, out_data_count[23:0]};
		end else if ((state == ft245_frame_pkg::TX_HEADER) && tx_byte_take) begin
			hdr_sr <= hdr_sr << 8;
		end
		if (pop_strobe) begin
			word_sr <= pop_word;
		end else if ((state == ft245_frame_pkg::TX_DATA) && tx_byte_take) begin
			word_sr <= word_sr << 8;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ft245_frame_pkg::TX_IDLE;
			hdr_idx    <= '0;
			byte_idx   <= '0;
			word_full  <= 1'b0;
			words_left <= '0;
			pull_wait  <= 1'b0;
		end else begin
			pull_wait <= pull;

			// pop_strobe only comes back while word_full is low
			if (pop_strobe) begin
				word_full <= 1'b1;
			end

			case (state)
				ft245_frame_pkg::TX_IDLE: begin
					if (oh_en) begin
						hdr_idx    <= '0;
						byte_idx   <= '0;
						words_left <= {4'h0, out_data_count[23:0]};
						state      <= ft245_frame_pkg::TX_HEADER;
					end
				end
				ft245_frame_pkg::TX_HEADER: begin
					if (tx_byte_take) begin
						hdr_idx <= hdr_idx + 4'd1;
						if (hdr_idx == 4'(`FT_HDR_OUT_BYTES - 1)) begin
							if (words_left == '0) begin
								state <= ft245_frame_pkg::TX_IDLE;
							end else begin
								state <= ft245_frame_pkg::TX_DATA;
							end
						end
					end
				end
				ft245_frame_pkg::TX_DATA: begin
					if (tx_byte_take) begin
						byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'd3) begin
							// last byte of the word frees the slot for the next pull
							word_full  <= 1'b0;
							words_left <= words_left - 1'b1;
							if (words_left == 28'd1) begin
								state <= ft245_frame_pkg::TX_IDLE;
							end
						end
					end
				end
				default: begin
					state <= ft245_frame_pkg::TX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/ft245_bridge.sv
// chip and host share clk, host may write out_data only while oh_ready is high
`timescale 1ns/1ps
`default_nettype none
`include "ft245_macros.svh"

module ft245_bridge (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          master_ready,
	input  wire                          oh_en,
	input  wire ft245_frame_pkg::word_t  out_status,
	input  wire ft245_frame_pkg::word_t  out_address,
	input  wire ft245_frame_pkg::count_t out_data_count,
	input  wire ft245_frame_pkg::word_t  out_data,
	input  wire                          out_data_wr,
	input  wire                          ftdi_rde_n,
	input  wire                          ftdi_txe_n,
	output wire                          ih_ready,
	output wire ft245_frame_pkg::word_t  in_command,
	output wire ft245_frame_pkg::word_t  in_address,
	output wire ft245_frame_pkg::count_t in_data_count,
	output wire ft245_frame_pkg::word_t  in_data,
	output wire                          in_data_strobe,
	output wire                          oh_ready,
	output wire                          out_busy,
	output wire                          ftdi_rd_n,
	output wire                          ftdi_wr_n,
	output wire                          ftdi_oe_n,
	inout  wire ft245_pin_pkg::ft_byte_t ftdi_data
);

	// rx path
	wire ft245_pin_pkg::ft_byte_t rx_byte;
	wire rx_byte_strobe;
	wire rx_hold;
	wire rx_push;
	wire ft245_frame_pkg::word_t rx_push_word;
	wire ft245_frame_pkg::command_t in_cmd;

	// tx path
	wire ft245_pin_pkg::ft_byte_t tx_byte;
	wire tx_byte_valid;
	wire tx_byte_take;
	wire tx_pull;
	wire ft245_frame_pkg::word_t tx_pop_word;
	wire tx_pop_strobe;
	wire ft245_pin_pkg::ft_byte_t data_drive;

	// the chip only listens with oe_n high and wr_n low, so drive the bus only then
	assign ftdi_data = (ftdi_oe_n && !ftdi_wr_n) ? data_drive : 'z;

	// command byte sits in the low bits of the host port
	assign in_command = {24'h0, in_cmd};

	ft245_pin_seq u_pin_seq (
		.clk            (clk),
		.rst            (rst),
		.ftdi_rde_n     (ftdi_rde_n),
		.ftdi_txe_n     (ftdi_txe_n),
		.ftdi_data_in   (ftdi_data),
		.rx_hold        (rx_hold),
		.tx_byte        (tx_byte),
		.tx_byte_valid  (tx_byte_valid),
		.ftdi_rd_n      (ftdi_rd_n),
		.ftdi_wr_n      (ftdi_wr_n),
		.ftdi_oe_n      (ftdi_oe_n),
		.ftdi_data_drive(data_drive),
		.rx_byte        (rx_byte),
		.rx_byte_strobe (rx_byte_strobe),
		.tx_byte_take   (tx_byte_take)
	);

	frame_deframer u_deframer (
		.clk           (clk),
		.rst           (rst),
		.rx_byte       (rx_byte),
		.rx_byte_strobe(rx_byte_strobe),
		.in_command    (in_cmd),
		.in_data_count (in_data_count),
		.in_address    (in_address),
		.ih_ready      (ih_ready),
		.push          (rx_push),
		.push_word     (rx_push_word)
	);

	// the host drains this one at its own pace through master_ready
	word_fifo #(.DEPTH_LOG2(`FT_RX_DEPTH_LOG2)) u_rx_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (rx_push),
		.push_word (rx_push_word),
		.pull      (master_ready),
		.pop_word  (in_data),
		.pop_strobe(in_data_strobe),
		.room      (),
		.hold      (rx_hold)
	);

	word_fifo #(.DEPTH_LOG2(`FT_TX_DEPTH_LOG2)) u_tx_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (out_data_wr),
		.push_word (out_data),
		.pull      (tx_pull),
		.pop_word  (tx_pop_word),
		.pop_strobe(tx_pop_strobe),
		.room      (oh_ready),
		.hold      ()
	);

	frame_framer u_framer (
		.clk           (clk),
		.rst           (rst),
		.oh_en         (oh_en),
		.out_status    (out_status),
		.out_address   (out_address),
		.out_data_count(out_data_count),
		.pop_word      (tx_pop_word),
		.pop_strobe    (tx_pop_strobe),
		.tx_byte_take  (tx_byte_take),
		.out_busy      (out_busy),
		.pull          (tx_pull),
		.tx_byte       (tx_byte),
		.tx_byte_valid (tx_byte_valid)
	);

endmodule

`default_nettype wire

//--- tb/ft_chip_model.sv
// behavioral chip on clk, its pins change 1 ns after the rising edge and sent bytes show one cycle late
`timescale 1ns/1ps
`default_nettype none

module ft_chip_model #(
	parameter integer SEED = 32'h744f
) (
	input  wire                      clk,
	input  wire                      ftdi_rd_n,
	input  wire                      ftdi_wr_n,
	input  wire                      ftdi_oe_n,
	inout  wire [7:0]                ftdi_data,
	output logic                     ftdi_rde_n,
	output logic                     ftdi_txe_n,
	output ft245_pin_pkg::ft_byte_t  sent_byte,
	output logic                     sent_strobe,
	output wire                      bus_ok
);

	// bytes waiting to go from the host PC to the device
	ft245_pin_pkg::ft_byte_t rx_q[$];
	ft245_pin_pkg::ft_byte_t rd_data;
	integer seed;
	integer full_cycles;

	// the chip only drives the bus while the device holds oe_n low
	assign ftdi_data = ftdi_oe_n ? 8'hzz : rd_data;

	// with both ends quiet the bus floats, a device write must be clean, and a read is chip only
	assign bus_ok = ftdi_oe_n ?
		(ftdi_wr_n ? (ftdi_data === 8'hzz) : (^ftdi_data !== 1'bx)) :
		(ftdi_data === rd_data);

	task automatic queue_byte(input ft245_pin_pkg::ft_byte_t b);
		rx_q.push_back(b);
	endtask

	initial begin
		seed = SEED;
		full_cycles = 0;
		ftdi_rde_n = 1'b1;
		ftdi_txe_n = 1'b1;
		rd_data = 8'h00;
		sent_byte = 8'h00;
		sent_strobe = 1'b0;
	end

	always @(posedge clk) begin
		// the device strobes read here are still the ones it set on the last edge
		sent_strobe <= !ftdi_wr_n && !ftdi_txe_n;
		sent_byte <= ftdi_data;
		if (!ftdi_rd_n && !ftdi_rde_n) begin
			void'(rx_q.pop_front());
		end
		#1;
		// a full chip keeps txe_n high for a short random stretch
		if (full_cycles > 0) begin
			full_cycles = full_cycles - 1;
			ftdi_txe_n <= 1'b1;
		end else if (({$random(seed)} % 8) == 0) begin
			full_cycles = {$random(seed)} % 6;
			ftdi_txe_n <= 1'b1;
		end else begin
			ftdi_txe_n <= 1'b0;
		end
		// an empty queue and a random gap look the same to the device
		ftdi_rde_n <= (rx_q.size() == 0) || (({$random(seed)} % 8) == 0);
		rd_data <= (rx_q.size() == 0) ? 8'h00 : rx_q[0];
	end

endmodule

`default_nettype wire

//--- tb/ft245_tb.sv
// random frames both ways on one clock, the run stops at the first wrong value
`timescale 1ns/1ps
`default_nettype none

module ft245_tb;

	localparam int FRAMES = 20;

	logic clk;
	logic rst;
	logic master_ready;
	logic oh_en;
	ft245_frame_pkg::word_t out_status;
	ft245_frame_pkg::word_t out_address;
	ft245_frame_pkg::count_t out_data_count;
	ft245_frame_pkg::word_t out_data;
	logic out_data_wr;

	wire ih_ready;
	wire [31:0] in_command;
	wire [31:0] in_address;
	wire [27:0] in_data_count;
	wire [31:0] in_data;
	wire in_data_strobe;
	wire oh_ready;
	wire out_busy;
	wire ftdi_rd_n;
	wire ftdi_wr_n;
	wire ftdi_oe_n;
	wire ftdi_rde_n;
	wire ftdi_txe_n;
	wire [7:0] ftdi_data;
	wire [7:0] sent_byte;
	wire sent_strobe;
	wire bus_ok;

	// inbound stimulus and what the host port should see, header packed as command, count, address
	ft245_pin_pkg::ft_byte_t in_bytes[$];
	int in_frame_len[$];
	int in_gaps[$];
	logic [67:0] exp_hdr[$];
	ft245_frame_pkg::word_t exp_in_words[$];

	// outbound stimulus and the byte stream the chip should record
	ft245_frame_pkg::word_t out_stat_q[$];
	ft245_frame_pkg::word_t out_addr_q[$];
	ft245_frame_pkg::count_t out_count_q[$];
	ft245_frame_pkg::word_t out_words[$];
	int out_delays[$];
	ft245_pin_pkg::ft_byte_t exp_out_bytes[$];

	integer seed;
	int cycles = 0;
	int cycle_limit = 2000;
	int errors = 0;
	int stall_cycles = 0;
	logic prev_wr_n = 1'b1;
	logic prev_rde_n = 1'b1;
	logic [67:0] hdr_exp;
	ft245_frame_pkg::word_t word_exp;
	ft245_pin_pkg::ft_byte_t byte_exp;

	ft245_bridge u_dut (
		.clk           (clk),
		.rst           (rst),
		.master_ready  (master_ready),
		.oh_en         (oh_en),
		.out_status    (out_status),
		.out_address   (out_address),
		.out_data_count(out_data_count),
		.out_data      (out_data),
		.out_data_wr   (out_data_wr),
		.ftdi_rde_n    (ftdi_rde_n),
		.ftdi_txe_n    (ftdi_txe_n),
		.ih_ready      (ih_ready),
		.in_command    (in_command),
		.in_address    (in_address),
		.in_data_count (in_data_count),
		.in_data       (in_data),
		.in_data_strobe(in_data_strobe),
		.oh_ready      (oh_ready),
		.out_busy      (out_busy),
		.ftdi_rd_n     (ftdi_rd_n),
		.ftdi_wr_n     (ftdi_wr_n),
		.ftdi_oe_n     (ftdi_oe_n),
		.ftdi_data     (ftdi_data)
	);

	ft_chip_model #(.SEED(32'h744f)) u_chip (
		.clk        (clk),
		.ftdi_rd_n  (ftdi_rd_n),
		.ftdi_wr_n  (ftdi_wr_n),
		.ftdi_oe_n  (ftdi_oe_n),
		.ftdi_data  (ftdi_data),
		.ftdi_rde_n (ftdi_rde_n),
		.ftdi_txe_n (ftdi_txe_n),
		.sent_byte  (sent_byte),
		.sent_strobe(sent_strobe),
		.bus_ok     (bus_ok)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic report_mismatch(input string what);
		errors++;
		$display("[FAIL] %0t ns: %s", $time, what);
		$display("Errors found");
		$fatal(1, "stopped at the first mismatch");
	endtask

	// frames are drawn up front so the run time and the limit are known before reset
	task automatic build_frames(output int total);
		ft245_frame_pkg::command_t cmd;
		ft245_frame_pkg::count_t cnt;
		ft245_frame_pkg::word_t addr;
		ft245_frame_pkg::word_t stat;
		ft245_frame_pkg::word_t w;
		total = 0;
		for (int f = 0; f < FRAMES; f++) begin
			cmd = $random(seed);
			addr = $random(seed);
			// every fifth frame carries no data words
			cnt = (f % 5 == 0) ? 28'd0 : 28'({$random(seed)} % 13);
			exp_hdr.push_back({cmd, cnt, addr});
			in_frame_len.push_back(8 + 4 * cnt);
			in_gaps.push_back({$random(seed)} % 12);
			in_bytes.push_back(cmd);
			for (int b = 2; b >= 0; b--) in_bytes.push_back(cnt[8*b +: 8]);
			for (int b = 3; b >= 0; b--) in_bytes.push_back(addr[8*b +: 8]);
			for (int i = 0; i < cnt; i++) begin
				w = $random(seed);
				exp_in_words.push_back(w);
				for (int b = 3; b >= 0; b--) in_bytes.push_back(w[8*b +: 8]);
			end
			total += 8 + 4 * cnt;

			stat = $random(seed);
			addr = $random(seed);
			cnt = (f % 5 == 2) ? 28'd0 : 28'({$random(seed)} % 13);
			out_stat_q.push_back(stat);
			out_addr_q.push_back(addr);
			out_count_q.push_back(cnt);
			// outbound header is status, address and the low 24 count bits, all big endian
			for (int b = 3; b >= 0; b--) exp_out_bytes.push_back(stat[8*b +: 8]);
			for (int b = 3; b >= 0; b--) exp_out_bytes.push_back(addr[8*b +: 8]);
			for (int b = 2; b >= 0; b--) exp_out_bytes.push_back(cnt[8*b +: 8]);
			for (int i = 0; i < cnt; i++) begin
				w = $random(seed);
				out_words.push_back(w);
				// now and then a word comes long after the header
				out_delays.push_back((({$random(seed)} % 12) == 0) ? 20 + {$random(seed)} % 20 :
					{$random(seed)} % 3);
				for (int b = 3; b >= 0; b--) exp_out_bytes.push_back(w[8*b +: 8]);
			end
			total += 11 + 4 * cnt;
		end
	endtask

	// bytes go into the chip 2 ns after the edge, away from its own pin updates
	task automatic feed_inbound();
		int n;
		int gap;
		for (int f = 0; f < FRAMES; f++) begin
			n = in_frame_len.pop_front();
			gap = in_gaps.pop_front();
			@(posedge clk);
			#2;
			repeat (n) u_chip.queue_byte(in_bytes.pop_front());
			repeat (gap) @(posedge clk);
		end
	endtask

	task automatic send_outbound();
		int n;
		int delay;
		for (int f = 0; f < FRAMES; f++) begin
			@(posedge clk);
			#1;
			while (out_busy) begin
				@(posedge clk);
				#1;
			end
			out_status = out_stat_q.pop_front();
			out_address = out_addr_q.pop_front();
			out_data_count = out_count_q.pop_front();
			n = out_data_count;
			oh_en = 1'b1;
			@(posedge clk);
			#1;
			oh_en = 1'b0;
			for (int i = 0; i < n; i++) begin
				delay = out_delays.pop_front();
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				while (!oh_ready) begin
					@(posedge clk);
					#1;
				end
				out_data = out_words.pop_front();
				out_data_wr = 1'b1;
				@(posedge clk);
				#1;
				out_data_wr = 1'b0;
			end
		end
	endtask

	// master_ready mostly toggles, with the odd long stall that fills the rx FIFO
	always @(posedge clk) begin
		#1;
		if (stall_cycles > 0) begin
			stall_cycles = stall_cycles - 1;
			master_ready = 1'b0;
		end else if (({$random(seed)} % 40) == 0) begin
			stall_cycles = 30 + {$random(seed)} % 40;
			master_ready = 1'b0;
		end else begin
			master_ready = $random(seed);
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("the run timed out after %0d cycles with frames still outstanding", cycles);
			$display("Errors found");
			$fatal(1, "timeout");
		end
	end

	// all outputs are sampled on the edge, before the DUT updates them
	always @(posedge clk) begin
		if (!rst) begin
			assert (bus_ok) else report_mismatch("ftdi_data driven while the other side owns it");
			// wr_n may only fall on an edge where the chip had no byte to offer
			assert (!(prev_wr_n && !ftdi_wr_n && !prev_rde_n))
				else report_mismatch("a write started while a read was pending");
			if (ih_ready) begin
				assert (exp_hdr.size() != 0) else report_mismatch("ih_ready with no frame outstanding");
				hdr_exp = exp_hdr.pop_front();
				assert (in_command == {24'h0, hdr_exp[67:60]} && in_data_count == hdr_exp[59:32] &&
					in_address == hdr_exp[31:0])
					else report_mismatch($sformatf("header %h %h %h, expected %h",
						in_command, in_data_count, in_address, hdr_exp));
			end
			if (in_data_strobe) begin
				assert (exp_in_words.size() != 0) else report_mismatch("extra word on in_data");
				word_exp = exp_in_words.pop_front();
				assert (in_data == word_exp)
					else report_mismatch($sformatf("in_data %h, expected %h", in_data, word_exp));
			end
			if (sent_strobe) begin
				assert (exp_out_bytes.size() != 0) else report_mismatch("extra byte sent to the chip");
				byte_exp = exp_out_bytes.pop_front();
				assert (sent_byte == byte_exp)
					else report_mismatch($sformatf("chip got %h, expected %h", sent_byte, byte_exp));
			end
		end
		prev_wr_n <= ftdi_wr_n;
		prev_rde_n <= ftdi_rde_n;
	end

	initial begin
		int total;
		seed = 32'h744f;
		rst = 1'b1;
		master_ready = 1'b0;
		oh_en = 1'b0;
		out_status = '0;
		out_address = '0;
		out_data_count = '0;
		out_data = '0;
		out_data_wr = 1'b0;
		build_frames(total);
		// every byte should move within a few cycles, plus room for host stalls
		cycle_limit = 4 * total + 2000;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		assert (ftdi_rd_n && ftdi_wr_n && ftdi_oe_n && !ih_ready && !in_data_strobe && !out_busy &&
			oh_ready)
			else report_mismatch("outputs not in their idle state after reset");
		fork
			feed_inbound();
			send_outbound();
		join
		while (exp_hdr.size() != 0 || exp_in_words.size() != 0 || exp_out_bytes.size() != 0) begin
			@(posedge clk);
		end
		// a stray word or byte would still show up in these cycles
		repeat (20) @(posedge clk);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/ft245_pin_pkg.sv
hw/ft245_frame_pkg.sv
hw/ft245_pin_seq.sv
hw/frame_deframer.sv
hw/word_fifo.sv
hw/frame_framer.sv
hw/ft245_bridge.sv
tb/ft_chip_model.sv
tb/ft245_tb.sv

//--- Bender.yml
package:
  name: ft245_bridge

sources:
  - include_dirs:
      - hw
    files:
      - hw/ft245_pin_pkg.sv
      - hw/ft245_frame_pkg.sv
      - hw/ft245_pin_seq.sv
      - hw/frame_deframer.sv
      - hw/word_fifo.sv
      - hw/frame_framer.sv
      - hw/ft245_bridge.sv
  - target: test
    files:
      - tb/ft_chip_model.sv
      - tb/ft245_tb.sv
